// ==== compile.f ====
+incdir+design
design/cnn_pkg.sv
design/feature_mem.sv
design/axil_slave.sv
design/conv_engine.sv
design/maxpool_unit.sv
design/layer_ctrl.sv
design/cnn_top.sv
tests/tb_clock.sv
tests/cnn_tb.sv

// ==== design/axil_slave.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module axil_slave (
    input  logic                clk,
    input  logic                reset,
    input  cnn_pkg::axi_addr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  cnn_pkg::axi_data_t  wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  cnn_pkg::axi_addr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output cnn_pkg::axi_data_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                busy,
    input  logic                done,
    input  cnn_pkg::pixel_t     res_data,
    output logic                img_we,
    output logic                ker_we,
    output logic                bias_we,
    output cnn_pkg::pix_addr_t  wr_index,
    output cnn_pkg::pixel_t     wr_data,
    output logic                start,
    output cnn_pkg::pool_addr_t res_addr
);
    localparam logic [9:0] CTRL_WORD = 10'(`CNN_REG_CTRL >> 2);
    localparam logic [9:0] BIAS_WORD = 10'(`CNN_REG_BIAS >> 2);
    localparam logic [9:0] KER_WORD  = 10'(`CNN_KER_BASE >> 2);
    localparam logic [9:0] IMG_WORD  = 10'(`CNN_IMG_BASE >> 2);
    localparam logic [9:0] RES_WORD  = 10'(`CNN_RES_BASE >> 2);
    localparam int KER_COUNT = `CNN_KER_DIM * `CNN_KER_DIM;
    localparam int IMG_COUNT = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int RES_COUNT = `CNN_POOL_DIM * `CNN_POOL_DIM;

    logic            w_ready;
    logic            wr_ok;
    logic [9:0]      wr_word;
    logic [9:0]      wr_ker_off;
    logic [9:0]      wr_img_off;
    logic [9:0]      rd_word;
    logic [9:0]      rd_ker_off;
    logic [9:0]      rd_img_off;
    logic [9:0]      rd_res_off;
    cnn_pkg::axi_data_t rd_mux;

    // readback copies of what was written into feature_mem
    cnn_pkg::pixel_t img_shadow [IMG_COUNT];
    cnn_pkg::pixel_t ker_shadow [KER_COUNT];
    cnn_pkg::pixel_t bias_shadow;

    function automatic logic in_region(logic [9:0] word, logic [9:0] base, int count);
        return (word >= base) && ((word - base) < count);
    endfunction

    function automatic cnn_pkg::axi_data_t sext(cnn_pkg::pixel_t p);
        return {{24{p[7]}}, p};
    endfunction

    assign awready = w_ready;
    assign wready  = w_ready;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    assign wr_word    = awaddr[`CNN_AXI_ADDR_W-1:2];
    assign wr_ker_off = wr_word - KER_WORD;
    assign wr_img_off = wr_word - IMG_WORD;

    // a write lands on the cycle both readies are up
    assign wr_ok   = w_ready && awvalid && wvalid && wstrb[0] && !busy;
    assign img_we  = wr_ok && in_region(wr_word, IMG_WORD, IMG_COUNT);
    assign ker_we  = wr_ok && in_region(wr_word, KER_WORD, KER_COUNT);
    assign bias_we = wr_ok && (wr_word == BIAS_WORD);
    assign start   = wr_ok && (wr_word == CTRL_WORD) && wdata[0];
    assign wr_data = wdata[7:0];
    assign wr_index = in_region(wr_word, KER_WORD, KER_COUNT) ? wr_ker_off[5:0]
                                                              : wr_img_off[5:0];

    assign rd_word    = araddr[`CNN_AXI_ADDR_W-1:2];
    assign rd_ker_off = rd_word - KER_WORD;
    assign rd_img_off = rd_word - IMG_WORD;
    assign rd_res_off = rd_word - RES_WORD;
    assign res_addr   = rd_res_off[3:0];

    always_comb begin
        rd_mux = '0;
        if (rd_word == CTRL_WORD)
            rd_mux = {30'b0, done, busy};
        else if (rd_word == BIAS_WORD)
            rd_mux = sext(bias_shadow);
        else if (in_region(rd_word, KER_WORD, KER_COUNT))
            rd_mux = sext(ker_shadow[rd_ker_off[4:0]]);
        else if (in_region(rd_word, IMG_WORD, IMG_COUNT))
            rd_mux = sext(img_shadow[rd_img_off[5:0]]);
        else if (in_region(rd_word, RES_WORD, RES_COUNT))
            rd_mux = sext(res_data);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (w_ready) begin
                w_ready <= 1'b0;
                bvalid  <= 1'b1;
            end else if (awvalid && wvalid && !bvalid) begin
                w_ready <= 1'b1;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            if (arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rdata   <= rd_mux;
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < IMG_COUNT; i++)
                img_shadow[i] <= '0;
            for (int i = 0; i < KER_COUNT; i++)
                ker_shadow[i] <= '0;
            bias_shadow <= '0;
        end else begin
            if (img_we)
                img_shadow[wr_index] <= wr_data;
            if (ker_we)
                ker_shadow[wr_index[4:0]] <= wr_data;
            if (bias_we)
                bias_shadow <= wr_data;
        end
    end

endmodule

// ==== design/cnn_cfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// layer geometry
`define CNN_IMG_DIM     8
`define CNN_KER_DIM     5
`define CNN_PAD         2
`define CNN_POOL_DIM    4

// fixed point scaling of the mac sum
`define CNN_SHIFT       4

// host register map, byte offsets
`define CNN_AXI_ADDR_W  12
`define CNN_REG_CTRL    12'h000
`define CNN_REG_BIAS    12'h004
`define CNN_KER_BASE    12'h100
`define CNN_IMG_BASE    12'h200
`define CNN_RES_BASE    12'h300

`endif

// ==== design/cnn_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_pkg;

    // picture value, weight, bias or pooled result
    typedef logic signed [7:0] pixel_t;

    // 25 products of 8x8 bits fit with margin
    typedef logic signed [19:0] acc_t;

    typedef logic [5:0] pix_addr_t;
    typedef logic [4:0] tap_t;
    typedef logic [3:0] pool_addr_t;

    typedef logic [`CNN_AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    typedef enum logic [1:0] {
        LAYER_IDLE,
        LAYER_CONV,
        LAYER_DONE
    } layer_state_t;

endpackage

// ==== design/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top (
    input  logic                clk,
    input  logic                reset,
    input  cnn_pkg::axi_addr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  cnn_pkg::axi_data_t  wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  cnn_pkg::axi_addr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output cnn_pkg::axi_data_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    logic                img_we;
    logic                ker_we;
    logic                bias_we;
    cnn_pkg::pix_addr_t  wr_index;
    cnn_pkg::pixel_t     wr_data;
    logic                start;
    logic                conv_start;
    logic                busy;
    logic                done;
    cnn_pkg::pix_addr_t  img_addr;
    cnn_pkg::tap_t       ker_addr;
    cnn_pkg::pixel_t     img_data;
    cnn_pkg::pixel_t     ker_data;
    cnn_pkg::pixel_t     bias;
    logic                pix_valid;
    cnn_pkg::pixel_t     pix_data;
    logic                conv_done;
    cnn_pkg::pool_addr_t res_addr;
    cnn_pkg::pixel_t     res_data;

    axil_slave u_axil (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .busy(busy), .done(done), .res_data(res_data),
        .img_we(img_we), .ker_we(ker_we), .bias_we(bias_we),
        .wr_index(wr_index), .wr_data(wr_data),
        .start(start), .res_addr(res_addr)
    );

    feature_mem u_mem (
        .clk(clk), .reset(reset),
        .img_we(img_we), .ker_we(ker_we), .bias_we(bias_we),
        .wr_index(wr_index), .wr_data(wr_data),
        .img_addr(img_addr), .ker_addr(ker_addr),
        .img_data(img_data), .ker_data(ker_data), .bias(bias)
    );

    layer_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .start(start), .conv_done(conv_done),
        .conv_start(conv_start), .busy(busy), .done(done)
    );

    conv_engine u_conv (
        .clk(clk), .reset(reset), .conv_start(conv_start),
        .img_data(img_data), .ker_data(ker_data), .bias(bias),
        .img_addr(img_addr), .ker_addr(ker_addr),
        .pix_valid(pix_valid), .pix_data(pix_data), .conv_done(conv_done)
    );

    maxpool_unit u_pool (
        .clk(clk), .reset(reset), .conv_start(conv_start),
        .pix_valid(pix_valid), .pix_data(pix_data),
        .res_addr(res_addr), .res_data(res_data)
    );

endmodule

// ==== design/conv_engine.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module conv_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               conv_start,
    input  cnn_pkg::pixel_t    img_data,
    input  cnn_pkg::pixel_t    ker_data,
    input  cnn_pkg::pixel_t    bias,
    output cnn_pkg::pix_addr_t img_addr,
    output cnn_pkg::tap_t      ker_addr,
    output logic               pix_valid,
    output cnn_pkg::pixel_t    pix_data,
    output logic               conv_done
);
    localparam int LAST_TAP = `CNN_KER_DIM * `CNN_KER_DIM - 1;
    localparam int LAST_POS = `CNN_IMG_DIM * `CNN_IMG_DIM - 1;

    logic               running;
    logic               finish;
    cnn_pkg::pix_addr_t pos;
    cnn_pkg::tap_t      tap;
    logic [2:0]         kx;
    logic [2:0]         ky;
    cnn_pkg::acc_t      acc;
    logic signed [4:0]  src_y;
    logic signed [4:0]  src_x;
    logic               in_pad;
    logic signed [15:0] product;
    cnn_pkg::acc_t      shifted;
    cnn_pkg::acc_t      biased;
    cnn_pkg::pixel_t    sat_pix;

    // tap position relative to the output pixel, may fall in the border
    assign src_y = $signed({2'b00, pos[5:3]}) + $signed({2'b00, ky}) - $signed(5'(`CNN_PAD));
    assign src_x = $signed({2'b00, pos[2:0]}) + $signed({2'b00, kx}) - $signed(5'(`CNN_PAD));
    assign in_pad = (src_y < 0) || (src_y >= `CNN_IMG_DIM) ||
                    (src_x < 0) || (src_x >= `CNN_IMG_DIM);

    assign img_addr = {src_y[2:0], src_x[2:0]};
    assign ker_addr = tap;
    assign product  = img_data * ker_data;

    always_comb begin
        shifted = acc >>> `CNN_SHIFT;
        biased  = shifted + cnn_pkg::acc_t'(bias);
        if (biased > 127)
            sat_pix = 8'sd127;
        else if (biased < -128)
            sat_pix = -8'sd128;
        else
            sat_pix = biased[7:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running   <= 1'b0;
            finish    <= 1'b0;
            pos       <= '0;
            tap       <= '0;
            kx        <= '0;
            ky        <= '0;
            acc       <= '0;
            pix_valid <= 1'b0;
            pix_data  <= '0;
            conv_done <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            conv_done <= 1'b0;
            if (conv_start) begin
                running <= 1'b1;
                finish  <= 1'b0;
                pos     <= '0;
                tap     <= '0;
                kx      <= '0;
                ky      <= '0;
                acc     <= '0;
            end else if (running && !finish) begin
                if (!in_pad)
                    acc <= acc + product;
                tap <= tap + 1'b1;
                if (kx == 3'(`CNN_KER_DIM - 1)) begin
                    kx <= '0;
                    ky <= ky + 1'b1;
                end else begin
                    kx <= kx + 1'b1;
                end
                if (tap == LAST_TAP)
                    finish <= 1'b1;
            end else if (running) begin
                // finishing cycle for this output pixel
                pix_valid <= 1'b1;
                pix_data  <= sat_pix;
                finish    <= 1'b0;
                tap       <= '0;
                kx        <= '0;
                ky        <= '0;
                acc       <= '0;
                if (pos == LAST_POS) begin
                    running   <= 1'b0;
                    conv_done <= 1'b1;
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/feature_mem.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module feature_mem (
    input  logic               clk,
    input  logic               reset,
    input  logic               img_we,
    input  logic               ker_we,
    input  logic               bias_we,
    input  cnn_pkg::pix_addr_t wr_index,
    input  cnn_pkg::pixel_t    wr_data,
    input  cnn_pkg::pix_addr_t img_addr,
    input  cnn_pkg::tap_t      ker_addr,
    output cnn_pkg::pixel_t    img_data,
    output cnn_pkg::pixel_t    ker_data,
    output cnn_pkg::pixel_t    bias
);
    localparam int IMG_WORDS = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int KER_WORDS = `CNN_KER_DIM * `CNN_KER_DIM;

    cnn_pkg::pixel_t img_mem [IMG_WORDS];
    cnn_pkg::pixel_t ker_mem [KER_WORDS];
    cnn_pkg::pixel_t bias_reg;

    // one shared write port, selected by the three enables
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < IMG_WORDS; i++)
                img_mem[i] <= '0;
            for (int i = 0; i < KER_WORDS; i++)
                ker_mem[i] <= '0;
            bias_reg <= '0;
        end else begin
            if (img_we)
                img_mem[wr_index] <= wr_data;
            if (ker_we)
                ker_mem[cnn_pkg::tap_t'(wr_index)] <= wr_data;
            if (bias_we)
                bias_reg <= wr_data;
        end
    end

    // combinational reads for the convolver
    assign img_data = img_mem[img_addr];
    assign ker_data = ker_mem[ker_addr];
    assign bias     = bias_reg;

endmodule

// ==== design/layer_ctrl.sv ====
`timescale 1ns/1ps

module layer_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic conv_done,
    output logic conv_start,
    output logic busy,
    output logic done
);
    cnn_pkg::layer_state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= cnn_pkg::LAYER_IDLE;
            conv_start <= 1'b0;
        end else begin
            conv_start <= 1'b0;
            case (state)
                cnn_pkg::LAYER_IDLE, cnn_pkg::LAYER_DONE: begin
                    if (start) begin
                        state      <= cnn_pkg::LAYER_CONV;
                        conv_start <= 1'b1;
                    end
                end
                cnn_pkg::LAYER_CONV: begin
                    if (conv_done)
                        state <= cnn_pkg::LAYER_DONE;
                end
                default: state <= cnn_pkg::LAYER_IDLE;
            endcase
        end
    end

    // done holds until the next start
    assign busy = (state == cnn_pkg::LAYER_CONV);
    assign done = (state == cnn_pkg::LAYER_DONE);

endmodule

// ==== design/maxpool_unit.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module maxpool_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                conv_start,
    input  logic                pix_valid,
    input  cnn_pkg::pixel_t     pix_data,
    input  cnn_pkg::pool_addr_t res_addr,
    output cnn_pkg::pixel_t     res_data
);
    localparam int RES_WORDS = `CNN_POOL_DIM * `CNN_POOL_DIM;

    cnn_pkg::pix_addr_t  pos;
    cnn_pkg::pixel_t     hold;
    cnn_pkg::pixel_t     row_buf [`CNN_POOL_DIM];
    cnn_pkg::pixel_t     res_mem [RES_WORDS];
    cnn_pkg::pixel_t     pair_max;
    cnn_pkg::pixel_t     block_max;
    logic [1:0]          col_pair;
    cnn_pkg::pool_addr_t wr_addr;

    assign col_pair  = pos[2:1];
    assign wr_addr   = {pos[5:4], pos[2:1]};
    assign pair_max  = (pix_data > hold) ? pix_data : hold;
    assign block_max = (pair_max > row_buf[col_pair]) ? pair_max : row_buf[col_pair];
    assign res_data  = res_mem[res_addr];

    // even column waits for its partner, even rows park the pair max
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            if (!pos[0])
                hold <= pix_data;
            else if (!pos[3])
                row_buf[col_pair] <= pair_max;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos <= '0;
            for (int i = 0; i < RES_WORDS; i++)
                res_mem[i] <= '0;
        end else if (conv_start) begin
            pos <= '0;
        end else if (pix_valid) begin
            pos <= pos + 1'b1;
            // odd row, odd column closes a 2x2 block
            if (pos[0] && pos[3])
                res_mem[wr_addr] <= block_max;
        end
    end

endmodule

// ==== tests/cnn_tb.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module cnn_tb;
    localparam int IMG_N = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int KER_N = `CNN_KER_DIM * `CNN_KER_DIM;
    localparam int RES_N = `CNN_POOL_DIM * `CNN_POOL_DIM;
    localparam int CONV_CYCLES = 1664;
    localparam int RUNS = 5;
    // roughly 220 transactions of up to 8 cycles per run
    localparam int AXI_CYCLES = 220 * 8;
    localparam int WATCHDOG_CYCLES = RUNS * 6 * CONV_CYCLES + (RUNS + 1) * AXI_CYCLES;
    localparam int HS_LIMIT = 50;
    localparam int POLL_LIMIT = 2 * CONV_CYCLES;

    logic               clk;
    logic               reset;
    cnn_pkg::axi_addr_t awaddr;
    logic               awvalid;
    logic               awready;
    cnn_pkg::axi_data_t wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    cnn_pkg::axi_addr_t araddr;
    logic               arvalid;
    logic               arready;
    cnn_pkg::axi_data_t rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;

    // host-side copy of what the DUT should hold
    cnn_pkg::pixel_t img_ref [IMG_N];
    cnn_pkg::pixel_t ker_ref [KER_N];
    cnn_pkg::pixel_t bias_ref;

    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    test_start_errors;
    string test_name;

    cnn_pkg::axi_data_t exp_q [$];
    cnn_pkg::axi_data_t got_q [$];
    string              name_q [$];
    bit                 pix_q [$];

    tb_clock u_clk (.clk(clk), .reset(reset));

    cnn_top uut (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    function automatic cnn_pkg::axi_data_t sign_extend(cnn_pkg::pixel_t p);
        return {{24{p[7]}}, p};
    endfunction

    function automatic cnn_pkg::axi_addr_t entry_addr(cnn_pkg::axi_addr_t base, int idx);
        return base + cnn_pkg::axi_addr_t'(4 * idx);
    endfunction

    // one convolved pixel with taps outside the picture as zero
    function automatic int conv_ref(int y, int x);
        int sum;
        int sy;
        int sx;
        sum = 0;
        for (int ky = 0; ky < `CNN_KER_DIM; ky++) begin
            for (int kx = 0; kx < `CNN_KER_DIM; kx++) begin
                sy = y + ky - `CNN_PAD;
                sx = x + kx - `CNN_PAD;
                if (sy >= 0 && sy < `CNN_IMG_DIM && sx >= 0 && sx < `CNN_IMG_DIM)
                    sum += int'(img_ref[sy * `CNN_IMG_DIM + sx]) *
                           int'(ker_ref[ky * `CNN_KER_DIM + kx]);
            end
        end
        sum = (sum >>> `CNN_SHIFT) + int'(bias_ref);
        if (sum > 127)
            sum = 127;
        else if (sum < -128)
            sum = -128;
        return sum;
    endfunction

    function automatic cnn_pkg::pixel_t pool_ref(int idx);
        int py;
        int px;
        int best;
        py = idx / `CNN_POOL_DIM;
        px = idx % `CNN_POOL_DIM;
        best = -1000;
        for (int dy = 0; dy < 2; dy++) begin
            for (int dx = 0; dx < 2; dx++) begin
                if (conv_ref(2 * py + dy, 2 * px + dx) > best)
                    best = conv_ref(2 * py + dy, 2 * px + dx);
            end
        end
        return cnn_pkg::pixel_t'(best);
    endfunction

    task automatic report_problem(string msg);
        errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic compare_pixel(string name, cnn_pkg::pixel_t exp, cnn_pkg::pixel_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic compare_status(string name, cnn_pkg::axi_data_t exp, cnn_pkg::axi_data_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        end
    endtask

    task automatic expect_word(string name, bit is_pix, cnn_pkg::axi_data_t exp,
                               cnn_pkg::axi_data_t got);
        name_q.push_back(name);
        pix_q.push_back(is_pix);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    task automatic axi_write(cnn_pkg::axi_addr_t addr, cnn_pkg::axi_data_t data, int hold);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(awready && wready) && n < HS_LIMIT);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!(awready && wready))
            report_problem($sformatf("write to 0x%03h was never accepted", addr));
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!bvalid && n < HS_LIMIT);
        if (!bvalid)
            report_problem($sformatf("no write response for 0x%03h", addr));
        // response must wait while bready is low
        repeat (hold) begin
            @(posedge clk);
            if (!bvalid)
                report_problem("bvalid dropped while bready was low");
        end
        if (bresp !== 2'b00)
            report_problem("write response was not OKAY");
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(cnn_pkg::axi_addr_t addr, int hold, output cnn_pkg::axi_data_t data);
        int n;
        cnn_pkg::axi_data_t first;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < HS_LIMIT);
        arvalid <= 1'b0;
        if (!arready)
            report_problem($sformatf("read of 0x%03h was never accepted", addr));
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < HS_LIMIT);
        if (!rvalid)
            report_problem($sformatf("no read data for 0x%03h", addr));
        first = rdata;
        repeat (hold) begin
            @(posedge clk);
            if (!rvalid)
                report_problem("rvalid dropped while rready was low");
            if (rdata !== first)
                report_problem("rdata changed while rready was low");
        end
        if (rresp !== 2'b00)
            report_problem("read response was not OKAY");
        rready <= 1'b1;
        @(posedge clk);
        data = rdata;
        rready <= 1'b0;
    endtask

    task automatic load_all();
        for (int i = 0; i < IMG_N; i++)
            axi_write(entry_addr(`CNN_IMG_BASE, i), sign_extend(img_ref[i]), 0);
        for (int i = 0; i < KER_N; i++)
            axi_write(entry_addr(`CNN_KER_BASE, i), sign_extend(ker_ref[i]), 0);
        axi_write(`CNN_REG_BIAS, sign_extend(bias_ref), 0);
    endtask

    task automatic verify_readback();
        cnn_pkg::axi_data_t d;
        for (int i = 0; i < IMG_N; i++) begin
            axi_read(entry_addr(`CNN_IMG_BASE, i), 0, d);
            expect_word($sformatf("picture[%0d]", i), 0, sign_extend(img_ref[i]), d);
        end
        for (int i = 0; i < KER_N; i++) begin
            axi_read(entry_addr(`CNN_KER_BASE, i), 0, d);
            expect_word($sformatf("kernel[%0d]", i), 0, sign_extend(ker_ref[i]), d);
        end
        axi_read(`CNN_REG_BIAS, 0, d);
        expect_word("bias", 0, sign_extend(bias_ref), d);
    endtask

    task automatic start_run();
        cnn_pkg::axi_data_t d;
        axi_write(`CNN_REG_CTRL, 32'h1, 0);
        axi_read(`CNN_REG_CTRL, 0, d);
        expect_word("ctrl after start", 0, 32'h1, d);
    endtask

    task automatic wait_done();
        cnn_pkg::axi_data_t d;
        int n;
        n = 0;
        do begin
            axi_read(`CNN_REG_CTRL, 0, d);
            n++;
        end while (!d[1] && n < POLL_LIMIT);
        if (!d[1])
            report_problem("done never rose after a start");
        else
            expect_word("ctrl at done", 0, 32'h2, d);
    endtask

    // const_exp selects a fixed expected value over the reference model
    task automatic check_results(bit const_exp, cnn_pkg::pixel_t value);
        cnn_pkg::axi_data_t d;
        cnn_pkg::pixel_t e;
        for (int i = 0; i < RES_N; i++) begin
            axi_read(entry_addr(`CNN_RES_BASE, i), 0, d);
            e = const_exp ? value : pool_ref(i);
            expect_word($sformatf("result[%0d]", i), 1, sign_extend(e), d);
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        int n;
        repeat (2) @(negedge clk);
        n = errors - test_start_errors;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, test_name, n);
        end
    endtask

    // compare process drains the queue on the falling edge
    initial begin
        cnn_pkg::axi_data_t e;
        cnn_pkg::axi_data_t g;
        string n;
        bit p;
        forever begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                e = exp_q.pop_front();
                g = got_q.pop_front();
                n = name_q.pop_front();
                p = pix_q.pop_front();
                if (p) begin
                    compare_pixel(n, e[7:0], g[7:0]);
                    if (g[31:8] !== {24{g[7]}})
                        report_problem($sformatf("%s is not sign extended", n));
                end else begin
                    compare_status(n, e, g);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run was stopped", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        cnn_pkg::axi_data_t d;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'h0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        d = $urandom(32'h7e50_62bf);
        @(negedge reset);

        start_test("reset state");
        axi_read(`CNN_REG_CTRL, 0, d);
        expect_word("ctrl", 0, 32'h0, d);
        check_results(1, 8'sd0);
        end_test();

        start_test("center tap");
        for (int i = 0; i < IMG_N; i++)
            img_ref[i] = 8'sd16;
        for (int i = 0; i < KER_N; i++)
            ker_ref[i] = (i == KER_N / 2) ? 8'sd1 : 8'sd0;
        bias_ref = 8'sd3;
        load_all();
        start_run();
        wait_done();
        check_results(1, 8'sd4);
        end_test();

        start_test("random data");
        for (int i = 0; i < IMG_N; i++)
            img_ref[i] = cnn_pkg::pixel_t'($urandom);
        for (int i = 0; i < KER_N; i++)
            ker_ref[i] = cnn_pkg::pixel_t'(int'($urandom % 16) - 8);
        bias_ref = cnn_pkg::pixel_t'($urandom);
        load_all();
        start_run();
        wait_done();
        check_results(0, 8'sd0);
        end_test();

        start_test("saturation");
        for (int i = 0; i < IMG_N; i++)
            img_ref[i] = 8'sd127;
        for (int i = 0; i < KER_N; i++)
            ker_ref[i] = 8'sd127;
        bias_ref = 8'sd100;
        load_all();
        start_run();
        wait_done();
        check_results(1, 8'sd127);
        for (int i = 0; i < KER_N; i++)
            ker_ref[i] = -8'sd128;
        load_all();
        start_run();
        wait_done();
        check_results(1, -8'sd128);
        end_test();

        start_test("readback and busy writes");
        for (int i = 0; i < IMG_N; i++)
            img_ref[i] = cnn_pkg::pixel_t'($urandom);
        // small weights keep most results out of saturation
        for (int i = 0; i < KER_N; i++)
            ker_ref[i] = cnn_pkg::pixel_t'(int'($urandom % 16) - 8);
        bias_ref = cnn_pkg::pixel_t'($urandom);
        load_all();
        verify_readback();
        start_run();
        // these land while busy and must not stick
        axi_write(entry_addr(`CNN_IMG_BASE, 0), sign_extend(~img_ref[0]), 0);
        axi_write(entry_addr(`CNN_IMG_BASE, 27), sign_extend(~img_ref[27]), 0);
        axi_write(entry_addr(`CNN_KER_BASE, 12), sign_extend(~ker_ref[12]), 0);
        axi_write(`CNN_REG_BIAS, sign_extend(~bias_ref), 0);
        verify_readback();
        wait_done();
        check_results(0, 8'sd0);
        end_test();

        start_test("unmapped reads and back-pressure");
        axi_read(12'h008, 0, d);
        expect_word("unmapped 0x008", 0, 32'h0, d);
        axi_read(12'h180, 0, d);
        expect_word("unmapped 0x180", 0, 32'h0, d);
        axi_read(12'h3fc, 0, d);
        expect_word("unmapped 0x3fc", 0, 32'h0, d);
        axi_write(`CNN_REG_BIAS, 32'h85, 6);
        axi_read(`CNN_REG_BIAS, 6, d);
        expect_word("bias under back-pressure", 0, 32'hffff_ff85, d);
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    localparam int HALF_NS = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
